/* src/scc_pkg.sv */
// Shared sizes, register offsets and the two-view address type for the dual wave-table block
package scc_pkg;

    // Chip and channel counts
    localparam int num_chips = 2;
    localparam int num_ch = 5;
    localparam int wave_len = 32;
    localparam int wave_idx_w = $clog2(wave_len);
    // Wide enough to number every channel wave block
    localparam int ch_w = 3;
    localparam int mem_idx_w = ch_w + wave_idx_w;
    localparam int mem_depth = num_ch * wave_len;

    // Data path widths
    localparam int sample_w = 8;
    localparam int vol_w = 4;
    localparam int period_w = 12;
    // One extra bit keeps the unsigned volume positive in the signed product
    localparam int prod_w = sample_w + vol_w + 1;
    localparam int chip_out_w = 15;
    localparam int sound_w = 16;
    localparam int ref_w = 8;

    // Standard register map
    localparam logic [7:0] std_freq_base = 8'h80;
    localparam logic [7:0] std_vol_base = 8'h8A;
    localparam logic [7:0] std_mask_addr = 8'h8F;

    // Extended register map, with the registers moved up into block 5
    localparam logic [7:0] plus_freq_base = 8'hA0;
    localparam logic [7:0] plus_vol_base = 8'hAA;
    localparam logic [7:0] plus_mask_addr = 8'hAF;

    // Standard view: bank 0 holds four channel waves, bank 1 the registers
    typedef struct packed {
        logic bank;
        logic [1:0] ch;
        logic [wave_idx_w-1:0] idx;
    } std_addr_t;

    // Extended view: blocks 0 to 4 are channel waves, block 5 the registers
    typedef struct packed {
        logic [2:0] blk;
        logic [wave_idx_w-1:0] idx;
    } plus_addr_t;

    typedef union packed {
        std_addr_t std_view;
        plus_addr_t plus_view;
    } scc_addr_u;

endpackage

/* src/scc_dev_ctrl.sv */
// Slot mode registers and chip selects derived from device references and CPU strobes
`timescale 1ns/1ps

module scc_dev_ctrl (
    input  logic cpu_bus,
    input  logic rst_n,
    input  logic cfg_en,
    input  logic [scc_pkg::ref_w-1:0] cfg_ref,
    input  logic cfg_mode,
    input  logic cfg_plus,
    input  logic dev_en,
    input  logic [scc_pkg::ref_w-1:0] dev_ref,
    input  logic [scc_pkg::num_chips-1:0] slot_enable,
    input  logic [scc_pkg::ref_w-1:0] slot_ref [scc_pkg::num_chips],
    input  logic rd,
    input  logic wr,
    output logic [scc_pkg::num_chips-1:0] chip_sel,
    output logic [scc_pkg::num_chips-1:0] plus_chip,
    output logic [scc_pkg::num_chips-1:0] plus_mode
);

    // A chip is selected while its slot is live, addressed and accessed
    always_comb begin
        for (int i = 0; i < scc_pkg::num_chips; i++) begin
            chip_sel[i] = slot_enable[i] && (slot_ref[i] == dev_ref) && dev_en && (rd || wr);
        end
    end

    // The configuration strobe updates only the slot whose reference matches
    always_ff @(posedge cpu_bus or negedge rst_n) begin
        if (!rst_n) begin
            plus_chip <= '0;
            plus_mode <= '0;
        end else if (cfg_en) begin
            for (int i = 0; i < scc_pkg::num_chips; i++) begin
                if (slot_ref[i] == cfg_ref) begin
                    plus_chip[i] <= cfg_plus;
                    plus_mode[i] <= cfg_mode;
                end
            end
        end
    end

endmodule

/* src/scc_wave.sv */
// Five-channel wave-table sound chip with CPU register access, wave memory and audio sequencer
`timescale 1ns/1ps

module scc_wave (
    input  logic cpu_bus,
    input  logic rst_n,
    input  logic ce_3m58,
    input  logic sel,
    input  logic wr,
    input  logic req,
    input  logic [7:0] addr,
    input  logic [7:0] wdata,
    input  logic plus_chip,
    input  logic plus_mode,
    output logic [7:0] rd_data,
    output logic signed [scc_pkg::chip_out_w-1:0] wave
);

    // Same address byte, read through either map
    scc_pkg::scc_addr_u addr_u;

    // Address decode
    logic ext_map;
    logic [7:0] freq_base;
    logic [7:0] vol_base;
    logic [7:0] mask_addr;
    logic [7:0] freq_off;
    logic [7:0] vol_off;
    logic wave_hit;
    logic freq_hit;
    logic vol_hit;
    logic mask_hit;
    logic [scc_pkg::ch_w-1:0] cpu_ch;
    logic [scc_pkg::wave_idx_w-1:0] cpu_idx;
    logic [scc_pkg::mem_idx_w-1:0] mem_idx;
    logic [scc_pkg::ch_w-1:0] freq_ch;
    logic [scc_pkg::ch_w-1:0] vol_ch;
    logic [7:0] rd_val;
    logic wr_en;

    // Register file and wave memory
    logic [scc_pkg::sample_w-1:0] wave_mem [scc_pkg::mem_depth];
    logic [scc_pkg::period_w-1:0] period [scc_pkg::num_ch];
    logic [scc_pkg::vol_w-1:0] volume [scc_pkg::num_ch];
    logic [scc_pkg::num_ch-1:0] ch_mask;

    // Sequencer state
    logic [scc_pkg::ch_w-1:0] seq_ch;
    logic [scc_pkg::period_w-1:0] cnt [scc_pkg::num_ch];
    logic [scc_pkg::wave_idx_w-1:0] phase [scc_pkg::num_ch];
    logic [scc_pkg::ch_w-1:0] play_ch;
    logic signed [scc_pkg::sample_w-1:0] sample;
    logic signed [scc_pkg::prod_w-1:0] prod;
    logic signed [scc_pkg::chip_out_w-1:0] acc;

    assign addr_u = addr;

    // The extended map needs both an extended chip and the extended mode bit
    assign ext_map = plus_chip && plus_mode;

    // A write lands on the edge where select, write and request are all high
    assign wr_en = sel && wr && req;

    always_comb begin
        freq_base = ext_map ? scc_pkg::plus_freq_base : scc_pkg::std_freq_base;
        vol_base = ext_map ? scc_pkg::plus_vol_base : scc_pkg::std_vol_base;
        mask_addr = ext_map ? scc_pkg::plus_mask_addr : scc_pkg::std_mask_addr;

        // Offsets wrap below the base, so one compare bounds each range
        freq_off = addr - freq_base;
        vol_off = addr - vol_base;
        freq_hit = freq_off < 8'(2 * scc_pkg::num_ch);
        vol_hit = vol_off < 8'(scc_pkg::num_ch);
        mask_hit = addr == mask_addr;
        // Frequency registers come in pairs, low byte first
        freq_ch = freq_off[3:1];
        vol_ch = vol_off[scc_pkg::ch_w-1:0];

        if (ext_map) begin
            // Every channel has its own block in the extended map
            wave_hit = addr_u.plus_view.blk < 3'(scc_pkg::num_ch);
            cpu_ch = addr_u.plus_view.blk;
            cpu_idx = addr_u.plus_view.idx;
        end else begin
            // Only channels 0 to 3 are reachable, channel 4 shares the last block
            wave_hit = !addr_u.std_view.bank;
            cpu_ch = {1'b0, addr_u.std_view.ch};
            cpu_idx = addr_u.std_view.idx;
        end
        mem_idx = {cpu_ch, cpu_idx};
    end

    // Read mux, anything unmapped returns all ones
    always_comb begin
        rd_val = 8'hFF;
        if (wave_hit) begin
            rd_val = wave_mem[mem_idx];
        end else if (freq_hit) begin
            if (freq_off[0]) begin
                rd_val = 8'(period[freq_ch][scc_pkg::period_w-1:8]);
            end else begin
                rd_val = period[freq_ch][7:0];
            end
        end else if (vol_hit) begin
            rd_val = 8'(volume[vol_ch]);
        end else if (mask_hit) begin
            rd_val = 8'(ch_mask);
        end
    end

    // CPU writes into the register file and wave memory
    always_ff @(posedge cpu_bus or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < scc_pkg::mem_depth; i++) begin
                wave_mem[i] <= '0;
            end
            for (int c = 0; c < scc_pkg::num_ch; c++) begin
                period[c] <= '0;
                volume[c] <= '0;
            end
            ch_mask <= '0;
        end else if (wr_en) begin
            if (wave_hit) begin
                wave_mem[mem_idx] <= wdata;
            end else if (freq_hit) begin
                // High register only carries the top nibble of the period
                if (freq_off[0]) begin
                    period[freq_ch][scc_pkg::period_w-1:8] <= wdata[3:0];
                end else begin
                    period[freq_ch][7:0] <= wdata;
                end
            end else if (vol_hit) begin
                volume[vol_ch] <= wdata[scc_pkg::vol_w-1:0];
            end else if (mask_hit) begin
                ch_mask <= wdata[scc_pkg::num_ch-1:0];
            end
        end
    end

    // Read data is sampled every edge and idles at all ones
    always_ff @(posedge cpu_bus or negedge rst_n) begin
        if (!rst_n) begin
            rd_data <= 8'hFF;
        end else if (sel && !(wr && req)) begin
            rd_data <= rd_val;
        end else begin
            rd_data <= 8'hFF;
        end
    end

    // Product of the current channel, zero when its mask bit is clear
    always_comb begin
        // In standard mode channel 4 plays the wave of channel 3
        if (!ext_map && seq_ch == 3'(scc_pkg::num_ch - 1)) begin
            play_ch = 3'(scc_pkg::num_ch - 2);
        end else begin
            play_ch = seq_ch;
        end
        sample = $signed(wave_mem[{play_ch, phase[seq_ch]}]);
        if (ch_mask[seq_ch]) begin
            prod = sample * $signed({1'b0, volume[seq_ch]});
        end else begin
            prod = '0;
        end
    end

    // One channel per clock enable, the sum is published after channel 4
    always_ff @(posedge cpu_bus or negedge rst_n) begin
        if (!rst_n) begin
            seq_ch <= '0;
            acc <= '0;
            wave <= '0;
            for (int c = 0; c < scc_pkg::num_ch; c++) begin
                cnt[c] <= '0;
                phase[c] <= '0;
            end
        end else if (ce_3m58) begin
            // Period count expired, so reload and step to the next sample
            if (cnt[seq_ch] == '0) begin
                cnt[seq_ch] <= period[seq_ch];
                phase[seq_ch] <= phase[seq_ch] + 1'b1;
            end else begin
                cnt[seq_ch] <= cnt[seq_ch] - 1'b1;
            end

            if (seq_ch == 3'(scc_pkg::num_ch - 1)) begin
                seq_ch <= '0;
                acc <= '0;
                wave <= acc + prod;
            end else begin
                seq_ch <= seq_ch + 1'b1;
                acc <= acc + prod;
            end
        end
    end

endmodule

/* src/scc_mix.sv */
// Sums the audio of both chips and merges their read data onto the CPU bus
`timescale 1ns/1ps

module scc_mix (
    input  logic signed [scc_pkg::chip_out_w-1:0] wave_a,
    input  logic signed [scc_pkg::chip_out_w-1:0] wave_b,
    input  logic [7:0] rd_data_a,
    input  logic [7:0] rd_data_b,
    input  logic [scc_pkg::num_chips-1:0] slot_enable,
    input  logic rd,
    output logic signed [scc_pkg::sound_w-1:0] sound,
    output logic [7:0] rdata
);

    localparam int ext_w = scc_pkg::sound_w - scc_pkg::chip_out_w;

    logic signed [scc_pkg::sound_w-1:0] part_a;
    logic signed [scc_pkg::sound_w-1:0] part_b;

    // Disabled slots drop out of the sum entirely
    always_comb begin
        part_a = '0;
        part_b = '0;
        if (slot_enable[0]) begin
            part_a = {{ext_w{wave_a[scc_pkg::chip_out_w-1]}}, wave_a};
        end
        if (slot_enable[1]) begin
            part_b = {{ext_w{wave_b[scc_pkg::chip_out_w-1]}}, wave_b};
        end
        sound = part_a + part_b;
    end

    // An idle chip drives all ones, so AND picks the one that answers
    assign rdata = rd ? (rd_data_a & rd_data_b) : 8'hFF;

endmodule

/* src/scc_dual.sv */
// Top level of the dual wave-table cartridge, joining slot control, both chips and the mixer
`timescale 1ns/1ps

module scc_dual (
    input  logic cpu_bus,
    input  logic rst_n,
    input  logic ce_3m58,
    input  logic rd,
    input  logic wr,
    input  logic req,
    input  logic [7:0] addr,
    input  logic [7:0] wdata,
    input  logic dev_en,
    input  logic [scc_pkg::ref_w-1:0] dev_ref,
    input  logic cfg_en,
    input  logic [scc_pkg::ref_w-1:0] cfg_ref,
    input  logic cfg_mode,
    input  logic cfg_plus,
    input  logic [scc_pkg::num_chips-1:0] slot_enable,
    input  logic [scc_pkg::ref_w-1:0] slot_ref [scc_pkg::num_chips],
    output logic [7:0] rdata,
    output logic signed [scc_pkg::sound_w-1:0] sound
);

    logic [scc_pkg::num_chips-1:0] chip_sel;
    logic [scc_pkg::num_chips-1:0] plus_chip;
    logic [scc_pkg::num_chips-1:0] plus_mode;
    logic [7:0] rd_data_a;
    logic [7:0] rd_data_b;
    logic signed [scc_pkg::chip_out_w-1:0] wave_a;
    logic signed [scc_pkg::chip_out_w-1:0] wave_b;

    scc_dev_ctrl u_dev_ctrl (
        .cpu_bus     (cpu_bus),
        .rst_n       (rst_n),
        .cfg_en      (cfg_en),
        .cfg_ref     (cfg_ref),
        .cfg_mode    (cfg_mode),
        .cfg_plus    (cfg_plus),
        .dev_en      (dev_en),
        .dev_ref     (dev_ref),
        .slot_enable (slot_enable),
        .slot_ref    (slot_ref),
        .rd          (rd),
        .wr          (wr),
        .chip_sel    (chip_sel),
        .plus_chip   (plus_chip),
        .plus_mode   (plus_mode)
    );

    // Slot 0 holds chip A
    scc_wave u_scc_a (
        .cpu_bus   (cpu_bus),
        .rst_n     (rst_n),
        .ce_3m58   (ce_3m58),
        .sel       (chip_sel[0]),
        .wr        (wr),
        .req       (req),
        .addr      (addr),
        .wdata     (wdata),
        .plus_chip (plus_chip[0]),
        .plus_mode (plus_mode[0]),
        .rd_data   (rd_data_a),
        .wave      (wave_a)
    );

    // Slot 1 holds chip B
    scc_wave u_scc_b (
        .cpu_bus   (cpu_bus),
        .rst_n     (rst_n),
        .ce_3m58   (ce_3m58),
        .sel       (chip_sel[1]),
        .wr        (wr),
        .req       (req),
        .addr      (addr),
        .wdata     (wdata),
        .plus_chip (plus_chip[1]),
        .plus_mode (plus_mode[1]),
        .rd_data   (rd_data_b),
        .wave      (wave_b)
    );

    scc_mix u_mix (
        .wave_a      (wave_a),
        .wave_b      (wave_b),
        .rd_data_a   (rd_data_a),
        .rd_data_b   (rd_data_b),
        .slot_enable (slot_enable),
        .rd          (rd),
        .sound       (sound),
        .rdata       (rdata)
    );

endmodule

/* verif/scc_tb.sv */
// Self-checking testbench for the dual wave-table block, run as the simulation top with flist.f
`timescale 1ns/1ps

module scc_tb;

    logic cpu_bus;
    logic rst_n;
    logic ce_3m58 = 1'b0;
    logic [1:0] ce_div = 2'd0;
    logic rd;
    logic wr;
    logic req;
    logic [7:0] addr;
    logic [7:0] wdata;
    logic dev_en;
    logic [7:0] dev_ref;
    logic cfg_en;
    logic [7:0] cfg_ref;
    logic cfg_mode;
    logic cfg_plus;
    logic [1:0] slot_enable;
    logic [7:0] slot_ref [2];
    logic [7:0] rdata;
    logic signed [15:0] sound;

    // Read results are compared by the checker process one cycle after sampling
    logic rd_due;
    logic [7:0] rd_exp;

    // Model of both chips, wave memory indexed as channel * 32 + sample
    logic [7:0] wave_m [2][160];
    logic [11:0] per_m [2][5];
    logic [3:0] vol_m [2][5];
    logic [4:0] mask_m [2];
    logic m_plus [2];
    logic m_mode [2];

    logic [31:0] seed = 32'd27;
    int errors = 0;
    int timeouts = 0;
    int checks = 0;

    scc_dual i_dut (
        .cpu_bus     (cpu_bus),
        .rst_n       (rst_n),
        .ce_3m58     (ce_3m58),
        .rd          (rd),
        .wr          (wr),
        .req         (req),
        .addr        (addr),
        .wdata       (wdata),
        .dev_en      (dev_en),
        .dev_ref     (dev_ref),
        .cfg_en      (cfg_en),
        .cfg_ref     (cfg_ref),
        .cfg_mode    (cfg_mode),
        .cfg_plus    (cfg_plus),
        .slot_enable (slot_enable),
        .slot_ref    (slot_ref),
        .rdata       (rdata),
        .sound       (sound)
    );

    initial begin
        cpu_bus = 1'b0;
        forever #50 cpu_bus = ~cpu_bus;
    end

    // The 3.58 MHz enable is one clock in four
    always @(posedge cpu_bus) begin
        ce_div <= ce_div + 2'd1;
        ce_3m58 <= (ce_div == 2'd3);
    end

    // Linear congruential generator, the upper middle bits are the best spread
    function automatic logic [7:0] next_rand();
        seed = seed * 32'd1103515245 + 32'd12345;
        return seed[23:16];
    endfunction

    task automatic check_value(input string name, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("[ERROR] t=%0t %s: got %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    // Chip answering a reference, or -1 when no enabled slot matches
    function automatic int target_chip(input logic [7:0] r);
        for (int i = 0; i < 2; i++) begin
            if (slot_enable[i] && slot_ref[i] == r) begin
                return i;
            end
        end
        return -1;
    endfunction

    // Returns a wave index below 1000, 1000 + frequency byte, 2000 + volume,
    // 3000 for the mask, or -1 when the offset is unmapped
    function automatic int decode_addr(input int chip, input logic [7:0] a);
        logic ext;
        int off;
        ext = m_plus[chip] && m_mode[chip];
        // Both maps put the wave blocks at the bottom, four of them or five
        if (int'(a) < (ext ? 'hA0 : 'h80)) begin
            return int'(a);
        end
        off = int'(a) - int'(ext ? scc_pkg::plus_freq_base : scc_pkg::std_freq_base);
        if (off >= 0 && off < 10) begin
            return 1000 + off;
        end
        if (off >= 10 && off < 15) begin
            return 2000 + off - 10;
        end
        if (off == 15) begin
            return 3000;
        end
        return -1;
    endfunction

    function automatic void model_write(input int chip, input logic [7:0] a,
                                        input logic [7:0] d);
        int k;
        k = decode_addr(chip, a);
        if (k < 0) begin
            return;
        end
        if (k < 1000) begin
            wave_m[chip][k] = d;
        end else if (k < 2000) begin
            // Odd frequency bytes hold the top nibble of the period
            if ((k - 1000) % 2 == 1) begin
                per_m[chip][(k - 1000) / 2][11:8] = d[3:0];
            end else begin
                per_m[chip][(k - 1000) / 2][7:0] = d;
            end
        end else if (k < 3000) begin
            vol_m[chip][k - 2000] = d[3:0];
        end else begin
            mask_m[chip] = d[4:0];
        end
    endfunction

    function automatic logic [7:0] expected_read(input int chip, input logic [7:0] a);
        int k;
        k = decode_addr(chip, a);
        if (k < 0) begin
            return 8'hFF;
        end
        if (k < 1000) begin
            return wave_m[chip][k];
        end
        if (k < 2000) begin
            if ((k - 1000) % 2 == 1) begin
                return {4'h0, per_m[chip][(k - 1000) / 2][11:8]};
            end
            return per_m[chip][(k - 1000) / 2][7:0];
        end
        if (k < 3000) begin
            return {4'h0, vol_m[chip][k - 2000]};
        end
        return {3'b000, mask_m[chip]};
    endfunction

    // Sum of sample times volume over enabled slots and unmasked channels,
    // valid because every waveform holds a single constant value
    function automatic int expected_sound();
        int sum;
        int play;
        int s;
        int v;
        sum = 0;
        for (int chip = 0; chip < 2; chip++) begin
            for (int ch = 0; ch < 5; ch++) begin
                if (slot_enable[chip] && mask_m[chip][ch]) begin
                    // Standard map has no separate channel 4 wave, it replays channel 3
                    play = (m_plus[chip] && m_mode[chip]) || ch < 4 ? ch : 3;
                    s = $signed(wave_m[chip][play * 32]);
                    v = int'(vol_m[chip][ch]);
                    sum += s * v;
                end
            end
        end
        return sum;
    endfunction

    task automatic write_reg(input logic [7:0] r, input logic [7:0] a, input logic [7:0] d);
        int chip;
        chip = target_chip(r);
        @(posedge cpu_bus);
        dev_en <= 1'b1;
        dev_ref <= r;
        wr <= 1'b1;
        req <= 1'b1;
        addr <= a;
        wdata <= d;
        @(posedge cpu_bus);
        dev_en <= 1'b0;
        wr <= 1'b0;
        req <= 1'b0;
        if (chip >= 0) begin
            model_write(chip, a, d);
        end
    endtask

    // Data is registered at the second edge and checked before the third
    task automatic read_check(input logic [7:0] r, input logic [7:0] a);
        int chip;
        chip = target_chip(r);
        @(posedge cpu_bus);
        rd <= 1'b1;
        dev_en <= 1'b1;
        dev_ref <= r;
        addr <= a;
        @(posedge cpu_bus);
        rd_due <= 1'b1;
        rd_exp <= (chip >= 0) ? expected_read(chip, a) : 8'hFF;
        @(posedge cpu_bus);
        rd <= 1'b0;
        dev_en <= 1'b0;
        rd_due <= 1'b0;
    endtask

    task automatic configure(input logic [7:0] r, input logic plus, input logic mode);
        @(posedge cpu_bus);
        cfg_en <= 1'b1;
        cfg_ref <= r;
        cfg_plus <= plus;
        cfg_mode <= mode;
        @(posedge cpu_bus);
        cfg_en <= 1'b0;
        for (int i = 0; i < 2; i++) begin
            if (slot_ref[i] == r) begin
                m_plus[i] = plus;
                m_mode[i] = mode;
            end
        end
    endtask

    // Fills each wave with one value, then sets volumes and the channel mask
    task automatic set_tone(input logic [7:0] r, input int nwaves, input logic [7:0] vol_addr,
                            input logic [7:0] mask);
        logic [7:0] v;
        for (int ch = 0; ch < nwaves; ch++) begin
            v = next_rand();
            for (int i = 0; i < 32; i++) begin
                write_reg(r, 8'(ch * 32 + i), v);
            end
        end
        for (int ch = 0; ch < 5; ch++) begin
            write_reg(r, vol_addr + 8'(ch), next_rand());
        end
        write_reg(r, vol_addr + 8'd5, mask);
    endtask

    task automatic wait_sound();
        int exp;
        int cycles;
        @(negedge cpu_bus);
        exp = expected_sound();
        cycles = 0;
        // A full round is 20 clocks, so 200 leaves a wide margin
        while (int'(sound) != exp && cycles < 200) begin
            @(negedge cpu_bus);
            cycles++;
        end
        if (cycles >= 200) begin
            timeouts++;
            $display("Timeout at %0t: sound did not settle to the model value", $time);
        end
        check_value("sound", int'(sound), exp);
    endtask

    // Checker for read data
    always @(negedge cpu_bus) begin
        if (rd_due) begin
            check_value("rdata", int'(rdata), int'(rd_exp));
        end
    end

    initial begin
        rst_n <= 1'b0;
        // Read strobe stays high through reset so rdata shows the chips' reset read data
        rd <= 1'b1;
        wr <= 1'b0;
        req <= 1'b0;
        addr <= 8'h00;
        wdata <= 8'h00;
        dev_en <= 1'b0;
        dev_ref <= 8'h00;
        cfg_en <= 1'b0;
        cfg_ref <= 8'h00;
        cfg_mode <= 1'b0;
        cfg_plus <= 1'b0;
        slot_enable <= 2'b11;
        slot_ref[0] <= 8'h11;
        slot_ref[1] <= 8'h22;
        rd_due <= 1'b0;
        rd_exp <= 8'hFF;
        for (int c = 0; c < 2; c++) begin
            for (int i = 0; i < 160; i++) begin
                wave_m[c][i] = 8'h00;
            end
            for (int ch = 0; ch < 5; ch++) begin
                per_m[c][ch] = 12'h000;
                vol_m[c][ch] = 4'h0;
            end
            mask_m[c] = 5'h00;
            m_plus[c] = 1'b0;
            m_mode[c] = 1'b0;
        end
        repeat (10) @(posedge cpu_bus);
        rst_n <= 1'b1;

        // Reset values seen right after release
        @(negedge cpu_bus);
        check_value("rdata", int'(rdata), 'hFF);
        check_value("sound", int'(sound), 0);
        @(posedge cpu_bus);
        rd <= 1'b0;

        // Chip A in the standard map, including the unmapped area above the mask
        for (int a = 0; a < 'hA0; a++) begin
            write_reg(slot_ref[0], 8'(a), next_rand());
        end
        // Full readback also shows channel 3's block holds channel 3
        for (int a = 0; a < 256; a++) begin
            read_check(slot_ref[0], 8'(a));
        end

        // Chip B extended type but still on the standard map
        configure(slot_ref[1], 1'b1, 1'b0);
        for (int a = 'h80; a < 'hB0; a++) begin
            write_reg(slot_ref[1], 8'(a), next_rand());
        end
        for (int a = 'h80; a < 'hB0; a++) begin
            read_check(slot_ref[1], 8'(a));
        end

        // Switch chip B to the extended map with a separate channel 4 wave
        configure(slot_ref[1], 1'b1, 1'b1);
        // The standard-map writes above 0x80 never reached the channel 4 wave
        for (int a = 'h80; a < 'hA0; a++) begin
            read_check(slot_ref[1], 8'(a));
        end
        for (int a = 'h80; a < 'hB0; a++) begin
            write_reg(slot_ref[1], 8'(a), next_rand());
        end
        for (int a = 0; a < 256; a++) begin
            read_check(slot_ref[1], 8'(a));
        end
        for (int a = 'h80; a < 'hB0; a++) begin
            read_check(slot_ref[0], 8'(a));
        end

        // Constant tones on both chips, chip B keeps channel 2 muted
        set_tone(slot_ref[0], 4, scc_pkg::std_vol_base, 8'h1F);
        set_tone(slot_ref[1], 5, scc_pkg::plus_vol_base, 8'h1B);
        wait_sound();

        // Slot B switched off drops out of the sum and stops answering
        @(posedge cpu_bus);
        slot_enable <= 2'b01;
        wait_sound();
        read_check(slot_ref[1], scc_pkg::plus_vol_base);
        write_reg(slot_ref[1], scc_pkg::plus_vol_base, 8'h0F);

        // A reference that matches no slot has no effect
        write_reg(8'h5A, scc_pkg::std_vol_base, 8'h07);
        read_check(8'h5A, scc_pkg::std_vol_base);
        read_check(8'h5A, 8'h00);
        read_check(slot_ref[0], scc_pkg::std_vol_base);

        @(posedge cpu_bus);
        slot_enable <= 2'b11;
        wait_sound();
        // Chip B kept its volume and its wave through both ignored writes
        read_check(slot_ref[1], scc_pkg::plus_vol_base);
        read_check(slot_ref[1], scc_pkg::std_vol_base);

        $display("Done: %0d checks, %0d errors, %0d timeouts", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* flist.f */
src/scc_pkg.sv
src/scc_dev_ctrl.sv
src/scc_wave.sv
src/scc_mix.sv
src/scc_dual.sv
verif/scc_tb.sv

/* Makefile */
# Verilator flow for the dual wave-table cartridge testbench

TOP := scc_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f flist.f --top-module $(TOP)
	verilator --lint-only src/scc_pkg.sv src/scc_dev_ctrl.sv src/scc_wave.sv \
		src/scc_mix.sv src/scc_dual.sv --top-module scc_dual

sim:
	verilator --binary --timing -Wno-fatal -f flist.f --top-module $(TOP) \
		-Mdir obj_dir -o $(TOP)_sim
	@out="$$(./obj_dir/$(TOP)_sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation PASSED"

clean:
	rm -rf obj_dir
